//--- src/params_pkg.sv
`default_nettype none

package params_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  localparam int DATA_WIDTH   = 32;
  localparam int ADDR_WIDTH   = 32;
  localparam int SHAMT_WIDTH  = 5;
  localparam int OPCODE_WIDTH = 7;
  localparam int INSTR_WIDTH  = 32;

  // ----------------------------------------
  // Vector types
  // ----------------------------------------
  typedef logic [DATA_WIDTH-1:0]   word_t;
  typedef logic [ADDR_WIDTH-1:0]   addr_t;
  typedef logic [INSTR_WIDTH-1:0]  instr_word_t;
  typedef logic [OPCODE_WIDTH-1:0] opcode_t;
  typedef logic [2:0]              funct3_t;
  typedef logic [6:0]              funct7_t;
  typedef logic [SHAMT_WIDTH-1:0]  shamt_t;
  typedef logic                    access_size_t;

  // Memory access size.
  localparam access_size_t BYTE = 1'b0;
  localparam access_size_t WORD = 1'b1;

  // ----------------------------------------
  // Opcodes, RV32I encodings
  // ----------------------------------------
  localparam opcode_t OP_R      = 7'b0110011;
  localparam opcode_t OP_LOAD   = 7'b0000011;
  localparam opcode_t OP_STORE  = 7'b0100011;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_IMM    = 7'b0010011;
  localparam opcode_t OP_LUI    = 7'b0110111;
  localparam opcode_t OP_AUIPC  = 7'b0010111;
  localparam opcode_t OP_SYSTEM = 7'b1110011;

  // Branch conditions.
  localparam funct3_t F3_BEQ = 3'b000;
  localparam funct3_t F3_BNE = 3'b001;
  localparam funct3_t F3_BLT = 3'b100;
  localparam funct3_t F3_BGE = 3'b101;

  // ALU operations.
  localparam funct3_t F3_ADD = 3'b000;
  localparam funct3_t F3_SLL = 3'b001;
  localparam funct3_t F3_SLT = 3'b010;
  localparam funct3_t F3_XOR = 3'b100;
  localparam funct3_t F3_SRL = 3'b101;
  localparam funct3_t F3_OR  = 3'b110;
  localparam funct3_t F3_AND = 3'b111;

endpackage : params_pkg

`default_nettype wire

//--- src/imm_decode.sv
`default_nettype none

module imm_decode (
  input  wire  params_pkg::instr_word_t instr_i,
  output params_pkg::opcode_t           opcode_o,
  output params_pkg::funct3_t           funct3_o,
  output params_pkg::funct7_t           funct7_o,
  output params_pkg::shamt_t            shamt_o,
  output params_pkg::word_t             offset_sign_extend_o
);

  // Field slices.
  assign opcode_o = instr_i[6:0];
  assign funct3_o = instr_i[14:12];
  assign funct7_o = instr_i[31:25];
  assign shamt_o  = instr_i[24:20];

  // ----------------------------------------
  // Immediate per format
  // ----------------------------------------
  always_comb begin
    case (opcode_o)
      params_pkg::OP_LOAD,
      params_pkg::OP_IMM,
      params_pkg::OP_SYSTEM: begin
        offset_sign_extend_o = {{20{instr_i[31]}}, instr_i[31:20]};
      end
      params_pkg::OP_STORE: begin
        offset_sign_extend_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
      end
      params_pkg::OP_BRANCH: begin
        // Bit 0 is implied zero.
        offset_sign_extend_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                                instr_i[30:25], instr_i[11:8], 1'b0};
      end
      params_pkg::OP_JAL: begin
        offset_sign_extend_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                                instr_i[20], instr_i[30:21], 1'b0};
      end
      params_pkg::OP_LUI,
      params_pkg::OP_AUIPC: begin
        offset_sign_extend_o = {instr_i[31:12], 12'b0};
      end
      default: begin
        offset_sign_extend_o = '0;
      end
    endcase
  end

endmodule : imm_decode

`default_nettype wire

//--- src/alu.sv
`default_nettype none

module alu #(
  parameter int DATA_WIDTH = params_pkg::DATA_WIDTH
)(
  input  wire params_pkg::opcode_t opcode_i,
  input  wire params_pkg::funct3_t funct3_i,
  input  wire params_pkg::funct7_t funct7_i,
  input  wire logic [DATA_WIDTH-1:0] a_i,
  input  wire logic [DATA_WIDTH-1:0] b_i,
  output logic [DATA_WIDTH-1:0] result_o,
  output logic is_zero_o,
  output logic is_less_o
);

  localparam int SHIFT_BITS = $clog2(DATA_WIDTH);

  logic [DATA_WIDTH-1:0] sum;
  logic [DATA_WIDTH-1:0] diff;
  logic [SHIFT_BITS-1:0] shift;
  logic                  alt;
  logic                  lt;

  assign sum   = a_i + b_i;
  assign diff  = a_i - b_i;
  assign shift = b_i[SHIFT_BITS-1:0];
  assign lt    = $signed(a_i) < $signed(b_i);

  // Selects SUB and SRA.
  assign alt = funct7_i[5];

  // ----------------------------------------
  // Result
  // ----------------------------------------
  always_comb begin
    result_o = sum;
    case (opcode_i)
      params_pkg::OP_R,
      params_pkg::OP_IMM: begin
        case (funct3_i)
          params_pkg::F3_ADD: begin
            // Immediate form has no subtract.
            result_o = (opcode_i == params_pkg::OP_R && alt) ? diff : sum;
          end
          params_pkg::F3_SLL: begin
            result_o = a_i << shift;
          end
          params_pkg::F3_SLT: begin
            result_o = {{(DATA_WIDTH-1){1'b0}}, lt};
          end
          params_pkg::F3_XOR: begin
            result_o = a_i ^ b_i;
          end
          params_pkg::F3_SRL: begin
            if (alt) begin
              result_o = DATA_WIDTH'($signed(a_i) >>> shift);
            end else begin
              result_o = a_i >> shift;
            end
          end
          params_pkg::F3_OR: begin
            result_o = a_i | b_i;
          end
          params_pkg::F3_AND: begin
            result_o = a_i & b_i;
          end
          default: begin
            result_o = sum;
          end
        endcase
      end
      params_pkg::OP_BRANCH: begin
        result_o = diff;
      end
      default: begin
        // Address and pass-through forms add.
        result_o = sum;
      end
    endcase
  end

  // Equality for branches, since the result is a - b there.
  assign is_zero_o = (result_o == '0);
  assign is_less_o = lt;

endmodule : alu

`default_nettype wire

//--- src/alu_stage.sv
`default_nettype none

module alu_stage #(
  parameter int DATA_WIDTH  = params_pkg::DATA_WIDTH,
  parameter int ADDR_WIDTH  = params_pkg::ADDR_WIDTH,
  parameter int SHAMT_WIDTH = params_pkg::SHAMT_WIDTH
)(
  input  wire logic valid_i,
  input  wire logic [ADDR_WIDTH-1:0] pc_i,
  input  wire logic [DATA_WIDTH-1:0] data_a_i,
  input  wire logic [DATA_WIDTH-1:0] data_b_i,
  input  wire params_pkg::opcode_t opcode_i,
  input  wire params_pkg::funct3_t funct3_i,
  input  wire params_pkg::funct7_t funct7_i,
  input  wire logic [SHAMT_WIDTH-1:0] shamt_i,
  input  wire logic [DATA_WIDTH-1:0] offset_sign_extend_i,
  output logic mem_valid_o,
  output logic mem_is_load_o,
  output logic mem_is_store_o,
  output logic mem_reg_wr_en_o,
  output params_pkg::access_size_t mem_access_size_o,
  output logic [DATA_WIDTH-1:0] mem_alu_result_o,
  output logic [DATA_WIDTH-1:0] mem_rs2_data_o,
  output logic [DATA_WIDTH-1:0] data_to_reg_o,
  output logic is_instr_wbalu_o,
  output logic instr_finishes_o,
  output logic branch_taken_o,
  output logic is_jump_o,
  output logic [ADDR_WIDTH-1:0] pc_branch_offset_o,
  output logic [ADDR_WIDTH-1:0] jump_address_o
);

  // LB and SB.
  localparam params_pkg::funct3_t F3_MEM_BYTE = 3'b000;

  logic [DATA_WIDTH-1:0] alu_a;
  logic [DATA_WIDTH-1:0] alu_b;
  logic [DATA_WIDTH-1:0] alu_result;
  logic [DATA_WIDTH-1:0] shamt_ext;
  logic is_zero;
  logic is_less;

  assign shamt_ext = {{(DATA_WIDTH-SHAMT_WIDTH){1'b0}}, shamt_i};

  // ----------------------------------------
  // Control and operand selection
  // ----------------------------------------
  always_comb begin
    mem_valid_o       = 1'b0;
    mem_is_load_o     = 1'b0;
    mem_is_store_o    = 1'b0;
    mem_reg_wr_en_o   = 1'b0;
    mem_access_size_o = params_pkg::WORD;
    is_jump_o         = 1'b0;
    branch_taken_o    = 1'b0;
    is_instr_wbalu_o  = 1'b0;
    instr_finishes_o  = 1'b0;
    alu_a             = data_a_i;
    alu_b             = data_b_i;

    case (opcode_i)
      params_pkg::OP_R: begin
        is_instr_wbalu_o = valid_i;
        instr_finishes_o = valid_i;
      end
      params_pkg::OP_LOAD,
      params_pkg::OP_STORE: begin
        mem_valid_o     = valid_i;
        mem_is_load_o   = (opcode_i == params_pkg::OP_LOAD);
        mem_is_store_o  = (opcode_i == params_pkg::OP_STORE);
        mem_reg_wr_en_o = (opcode_i == params_pkg::OP_LOAD);
        alu_b           = offset_sign_extend_i;
        mem_access_size_o = (funct3_i == F3_MEM_BYTE) ? params_pkg::BYTE : params_pkg::WORD;
      end
      params_pkg::OP_BRANCH: begin
        instr_finishes_o = valid_i;
        case (funct3_i)
          params_pkg::F3_BEQ: branch_taken_o = valid_i & is_zero;
          params_pkg::F3_BNE: branch_taken_o = valid_i & ~is_zero;
          params_pkg::F3_BLT: branch_taken_o = valid_i & is_less;
          params_pkg::F3_BGE: branch_taken_o = valid_i & ~is_less;
          default:            branch_taken_o = 1'b0;
        endcase
      end
      params_pkg::OP_JAL: begin
        // Link value is pc + 4.
        is_jump_o        = valid_i;
        is_instr_wbalu_o = valid_i;
        instr_finishes_o = valid_i;
        alu_a            = DATA_WIDTH'(pc_i);
        alu_b            = DATA_WIDTH'(4);
      end
      params_pkg::OP_IMM: begin
        is_instr_wbalu_o = valid_i;
        instr_finishes_o = valid_i;
        case (funct3_i)
          params_pkg::F3_SLL,
          params_pkg::F3_SRL: alu_b = shamt_ext;
          default:            alu_b = offset_sign_extend_i;
        endcase
      end
      params_pkg::OP_LUI: begin
        is_instr_wbalu_o = valid_i;
        instr_finishes_o = valid_i;
        alu_a            = '0;
        alu_b            = offset_sign_extend_i;
      end
      params_pkg::OP_AUIPC: begin
        is_instr_wbalu_o = valid_i;
        instr_finishes_o = valid_i;
        alu_a            = DATA_WIDTH'(pc_i);
        alu_b            = offset_sign_extend_i;
      end
      params_pkg::OP_SYSTEM: begin
        is_instr_wbalu_o = valid_i;
        instr_finishes_o = valid_i;
        alu_b            = offset_sign_extend_i;
      end
      default: begin
      end
    endcase
  end

  assign data_to_reg_o    = alu_result;
  assign mem_alu_result_o = alu_result;
  assign mem_rs2_data_o   = data_b_i;

  // Both targets are pc relative.
  assign pc_branch_offset_o = pc_i + ADDR_WIDTH'(offset_sign_extend_i);
  assign jump_address_o     = pc_i + ADDR_WIDTH'(offset_sign_extend_i);

  alu #(
    .DATA_WIDTH (DATA_WIDTH)
  ) alu_i (
    .opcode_i  (opcode_i),
    .funct3_i  (funct3_i),
    .funct7_i  (funct7_i),
    .a_i       (alu_a),
    .b_i       (alu_b),
    .result_o  (alu_result),
    .is_zero_o (is_zero),
    .is_less_o (is_less)
  );

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  // A branch sees equal operands only through a zero ALU difference.
  assert final (!(valid_i && opcode_i == params_pkg::OP_BRANCH) ||
                (is_zero == (data_a_i == data_b_i)))
    else $error("ALU zero flag disagrees with operand equality on a branch");

endmodule : alu_stage

`default_nettype wire

//--- src/ex_mem_reg.sv
`default_nettype none

module ex_mem_reg #(
  parameter int DATA_WIDTH = params_pkg::DATA_WIDTH
)(
  input  wire logic clk_i,
  input  wire logic rst_i,
  input  wire logic mem_stall_i,
  input  wire logic valid_i,
  input  wire logic is_load_i,
  input  wire logic is_store_i,
  input  wire logic reg_wr_en_i,
  input  wire params_pkg::access_size_t access_size_i,
  input  wire logic [DATA_WIDTH-1:0] alu_result_i,
  input  wire logic [DATA_WIDTH-1:0] rs2_data_i,
  output logic mem_valid_o,
  output logic mem_is_load_o,
  output logic mem_is_store_o,
  output logic mem_reg_wr_en_o,
  output params_pkg::access_size_t mem_access_size_o,
  output logic [DATA_WIDTH-1:0] mem_alu_result_o,
  output logic [DATA_WIDTH-1:0] mem_rs2_data_o
);

  // Reset wins over the stall.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mem_valid_o       <= 1'b0;
      mem_is_load_o     <= 1'b0;
      mem_is_store_o    <= 1'b0;
      mem_reg_wr_en_o   <= 1'b0;
      mem_access_size_o <= params_pkg::BYTE;
      mem_alu_result_o  <= '0;
      mem_rs2_data_o    <= '0;
    end else if (!mem_stall_i) begin
      mem_valid_o       <= valid_i;
      mem_is_load_o     <= is_load_i;
      mem_is_store_o    <= is_store_i;
      mem_reg_wr_en_o   <= reg_wr_en_i;
      mem_access_size_o <= access_size_i;
      mem_alu_result_o  <= alu_result_i;
      mem_rs2_data_o    <= rs2_data_i;
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  // The memory stage sees a frozen slot for the whole stall.
  stall_holds_a : assert property (
    @(posedge clk_i) disable iff (rst_i)
    mem_stall_i |=> $stable({mem_valid_o, mem_is_load_o, mem_is_store_o, mem_reg_wr_en_o,
                             mem_access_size_o, mem_alu_result_o, mem_rs2_data_o})
  ) else $error("EX/MEM register changed during a stall");

endmodule : ex_mem_reg

`default_nettype wire

//--- src/exec_unit.sv
`default_nettype none

module exec_unit #(
  parameter int DATA_WIDTH  = params_pkg::DATA_WIDTH,
  parameter int ADDR_WIDTH  = params_pkg::ADDR_WIDTH,
  parameter int SHAMT_WIDTH = params_pkg::SHAMT_WIDTH
)(
  input  wire logic clk_i,
  input  wire logic rst_i,
  input  wire logic valid_i,
  input  wire logic mem_stall_i,
  input  wire params_pkg::instr_word_t instr_i,
  input  wire logic [ADDR_WIDTH-1:0] pc_i,
  input  wire logic [DATA_WIDTH-1:0] data_a_i,
  input  wire logic [DATA_WIDTH-1:0] data_b_i,
  output logic [DATA_WIDTH-1:0] data_to_reg_o,
  output logic is_instr_wbalu_o,
  output logic instr_finishes_o,
  output logic branch_taken_o,
  output logic is_jump_o,
  output logic [ADDR_WIDTH-1:0] pc_branch_offset_o,
  output logic [ADDR_WIDTH-1:0] jump_address_o,
  output logic mem_valid_o,
  output logic mem_is_load_o,
  output logic mem_is_store_o,
  output logic mem_reg_wr_en_o,
  output params_pkg::access_size_t mem_access_size_o,
  output logic [DATA_WIDTH-1:0] mem_alu_result_o,
  output logic [DATA_WIDTH-1:0] mem_rs2_data_o
);

  params_pkg::opcode_t opcode;
  params_pkg::funct3_t funct3;
  params_pkg::funct7_t funct7;
  params_pkg::shamt_t  shamt;
  params_pkg::word_t   offset_sign_extend;

  // Same-cycle memory fields ahead of the register.
  logic ex_valid;
  logic ex_is_load;
  logic ex_is_store;
  logic ex_reg_wr_en;
  params_pkg::access_size_t ex_access_size;
  logic [DATA_WIDTH-1:0] ex_alu_result;
  logic [DATA_WIDTH-1:0] ex_rs2_data;

  imm_decode imm_decode_i (
    .instr_i              (instr_i),
    .opcode_o             (opcode),
    .funct3_o             (funct3),
    .funct7_o             (funct7),
    .shamt_o              (shamt),
    .offset_sign_extend_o (offset_sign_extend)
  );

  alu_stage #(
    .DATA_WIDTH  (DATA_WIDTH),
    .ADDR_WIDTH  (ADDR_WIDTH),
    .SHAMT_WIDTH (SHAMT_WIDTH)
  ) alu_stage_i (
    .valid_i              (valid_i),
    .pc_i                 (pc_i),
    .data_a_i             (data_a_i),
    .data_b_i             (data_b_i),
    .opcode_i             (opcode),
    .funct3_i             (funct3),
    .funct7_i             (funct7),
    .shamt_i              (shamt),
    .offset_sign_extend_i (offset_sign_extend),
    .mem_valid_o          (ex_valid),
    .mem_is_load_o        (ex_is_load),
    .mem_is_store_o       (ex_is_store),
    .mem_reg_wr_en_o      (ex_reg_wr_en),
    .mem_access_size_o    (ex_access_size),
    .mem_alu_result_o     (ex_alu_result),
    .mem_rs2_data_o       (ex_rs2_data),
    .data_to_reg_o        (data_to_reg_o),
    .is_instr_wbalu_o     (is_instr_wbalu_o),
    .instr_finishes_o     (instr_finishes_o),
    .branch_taken_o       (branch_taken_o),
    .is_jump_o            (is_jump_o),
    .pc_branch_offset_o   (pc_branch_offset_o),
    .jump_address_o       (jump_address_o)
  );

  ex_mem_reg #(
    .DATA_WIDTH (DATA_WIDTH)
  ) ex_mem_reg_i (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .mem_stall_i       (mem_stall_i),
    .valid_i           (ex_valid),
    .is_load_i         (ex_is_load),
    .is_store_i        (ex_is_store),
    .reg_wr_en_i       (ex_reg_wr_en),
    .access_size_i     (ex_access_size),
    .alu_result_i      (ex_alu_result),
    .rs2_data_i        (ex_rs2_data),
    .mem_valid_o       (mem_valid_o),
    .mem_is_load_o     (mem_is_load_o),
    .mem_is_store_o    (mem_is_store_o),
    .mem_reg_wr_en_o   (mem_reg_wr_en_o),
    .mem_access_size_o (mem_access_size_o),
    .mem_alu_result_o  (mem_alu_result_o),
    .mem_rs2_data_o    (mem_rs2_data_o)
  );

endmodule : exec_unit

`default_nettype wire

//--- bench/exec_ref.svh
`ifndef EXEC_REF_SVH
`define EXEC_REF_SVH

// Reference model of the execute stage from the RV32I rules.

function automatic logic [31:0] decode_imm(input logic [31:0] ins);
  case (ins[6:0])
    params_pkg::OP_LOAD, params_pkg::OP_IMM, params_pkg::OP_SYSTEM:
      return {{20{ins[31]}}, ins[31:20]};
    params_pkg::OP_STORE:
      return {{20{ins[31]}}, ins[31:25], ins[11:7]};
    params_pkg::OP_BRANCH:
      return {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    params_pkg::OP_JAL:
      return {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    params_pkg::OP_LUI, params_pkg::OP_AUIPC:
      return {ins[31:12], 12'b0};
    default:
      return '0;
  endcase
endfunction

// Register and immediate arithmetic. Only the register form subtracts.
function automatic logic [31:0] alu_op_value(input logic [2:0] f3, input logic alt,
                                             input logic is_reg, input logic [31:0] a,
                                             input logic [31:0] b);
  case (f3)
    3'b000: return (is_reg && alt) ? a - b : a + b;
    3'b001: return a << b[4:0];
    3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'b100: return a ^ b;
    3'b101: begin
      if (alt) begin
        return $signed(a) >>> b[4:0];
      end
      return a >> b[4:0];
    end
    3'b110: return a | b;
    3'b111: return a & b;
    default: return a + b;
  endcase
endfunction

function automatic logic [31:0] expected_result(input logic [31:0] ins, input logic [31:0] pc,
                                                input logic [31:0] a, input logic [31:0] b);
  logic [31:0] imm;
  imm = decode_imm(ins);
  case (ins[6:0])
    params_pkg::OP_R: return alu_op_value(ins[14:12], ins[30], 1'b1, a, b);
    params_pkg::OP_IMM: begin
      // Shift-immediates take the shamt field.
      if (ins[13:12] == 2'b01) begin
        return alu_op_value(ins[14:12], ins[30], 1'b0, a, {27'b0, ins[24:20]});
      end
      return alu_op_value(ins[14:12], ins[30], 1'b0, a, imm);
    end
    params_pkg::OP_LOAD, params_pkg::OP_STORE, params_pkg::OP_SYSTEM: return a + imm;
    params_pkg::OP_BRANCH: return a - b;
    params_pkg::OP_JAL: return pc + 32'd4;
    params_pkg::OP_LUI: return imm;
    params_pkg::OP_AUIPC: return pc + imm;
    default: return a + b;
  endcase
endfunction

function automatic logic branch_outcome(input logic [31:0] ins, input logic v,
                                        input logic [31:0] a, input logic [31:0] b);
  if (!v || ins[6:0] != params_pkg::OP_BRANCH) begin
    return 1'b0;
  end
  case (ins[14:12])
    3'b000: return a == b;
    3'b001: return a != b;
    3'b100: return $signed(a) < $signed(b);
    3'b101: return $signed(a) >= $signed(b);
    default: return 1'b0;
  endcase
endfunction

function automatic logic writes_alu_value(input logic [6:0] op, input logic v);
  case (op)
    params_pkg::OP_R, params_pkg::OP_IMM, params_pkg::OP_JAL, params_pkg::OP_LUI,
    params_pkg::OP_AUIPC, params_pkg::OP_SYSTEM: return v;
    default: return 1'b0;
  endcase
endfunction

function automatic logic is_known_op(input logic [6:0] op);
  case (op)
    params_pkg::OP_R, params_pkg::OP_IMM, params_pkg::OP_JAL, params_pkg::OP_LUI,
    params_pkg::OP_AUIPC, params_pkg::OP_SYSTEM, params_pkg::OP_LOAD,
    params_pkg::OP_STORE, params_pkg::OP_BRANCH: return 1'b1;
    default: return 1'b0;
  endcase
endfunction

`endif

//--- bench/exec_unit_tb.sv
`default_nettype none

module exec_unit_tb;

  localparam int RESET_CYCLES   = 2;
  localparam int R_SLOTS        = 32;
  localparam int IMM_SLOTS      = 32;
  localparam int BR_SLOTS       = 32;
  localparam int JAL_SLOTS      = 12;
  localparam int MEM_SLOTS      = 24;
  localparam int STALL_HOLD     = 4;
  localparam int STALL_SLOTS    = STALL_HOLD + 5;
  localparam int DRAIN_CYCLES   = 2;
  localparam int TOTAL_CYCLES   = RESET_CYCLES + R_SLOTS + IMM_SLOTS + BR_SLOTS + JAL_SLOTS
                                + MEM_SLOTS + STALL_SLOTS + 6 * DRAIN_CYCLES;
  localparam int TIMEOUT_CYCLES = 2 * TOTAL_CYCLES;

  logic        clk_i;
  logic        rst_i;
  logic        valid_i;
  logic        mem_stall_i;
  logic [31:0] instr_i;
  logic [31:0] pc_i;
  logic [31:0] data_a_i;
  logic [31:0] data_b_i;
  logic [31:0] data_to_reg_o;
  logic        is_instr_wbalu_o;
  logic        instr_finishes_o;
  logic        branch_taken_o;
  logic        is_jump_o;
  logic [31:0] pc_branch_offset_o;
  logic [31:0] jump_address_o;
  logic        mem_valid_o;
  logic        mem_is_load_o;
  logic        mem_is_store_o;
  logic        mem_reg_wr_en_o;
  logic        mem_access_size_o;
  logic [31:0] mem_alu_result_o;
  logic [31:0] mem_rs2_data_o;

  logic [31:0] lcg_state;
  logic        armed;
  int          error_count = 0;
  int          test_start_errors;
  int          tests_run;
  int          tests_failed;
  int          cycle_count;

  logic [31:0] exp_result;
  logic [31:0] exp_target;
  logic        exp_known;
  logic        exp_wbalu;
  logic        exp_finishes;
  logic        exp_branch;
  logic        exp_jump;
  logic        exp_is_load;
  logic        exp_is_store;
  logic        held_valid;
  logic        held_load;
  logic        held_store;
  logic        held_access;
  logic [31:0] held_result;
  logic [31:0] held_rs2;

  `include "exec_ref.svh"

  exec_unit exec_unit_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // ----------------------------------------
  // Expected values
  // ----------------------------------------
  assign exp_result   = expected_result(instr_i, pc_i, data_a_i, data_b_i);
  assign exp_target   = pc_i + decode_imm(instr_i);
  assign exp_known    = is_known_op(instr_i[6:0]);
  assign exp_wbalu    = writes_alu_value(instr_i[6:0], valid_i);
  assign exp_finishes = exp_wbalu || (valid_i && instr_i[6:0] == params_pkg::OP_BRANCH);
  assign exp_branch   = branch_outcome(instr_i, valid_i, data_a_i, data_b_i);
  assign exp_jump     = valid_i && instr_i[6:0] == params_pkg::OP_JAL;
  assign exp_is_load  = instr_i[6:0] == params_pkg::OP_LOAD;
  assign exp_is_store = instr_i[6:0] == params_pkg::OP_STORE;

  // Expected EX/MEM contents. Reset first, then load unless stalled.
  always @(posedge clk_i) begin
    if (rst_i) begin
      held_valid <= 1'b0;
      held_load  <= 1'b0;
      held_store <= 1'b0;
    end else if (!mem_stall_i) begin
      held_valid  <= valid_i && (exp_is_load || exp_is_store);
      held_load   <= exp_is_load;
      held_store  <= exp_is_store;
      held_access <= (instr_i[14:12] == 3'b000) ? params_pkg::BYTE : params_pkg::WORD;
      held_result <= exp_result;
      held_rs2    <= data_b_i;
    end
  end

  task automatic flag_mismatch(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    $display("ERR t=%0t %s expected %h got %h", $time, name, expected, actual);
    error_count++;
  endtask

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  data_to_reg_a : assert property (@(posedge clk_i) armed && exp_known |->
    data_to_reg_o == exp_result)
    else flag_mismatch("data_to_reg_o", $sampled(exp_result), $sampled(data_to_reg_o));
  wbalu_a : assert property (@(posedge clk_i) armed |-> is_instr_wbalu_o == exp_wbalu)
    else flag_mismatch("is_instr_wbalu_o", $sampled(exp_wbalu), $sampled(is_instr_wbalu_o));
  finishes_a : assert property (@(posedge clk_i) armed |-> instr_finishes_o == exp_finishes)
    else flag_mismatch("instr_finishes_o", $sampled(exp_finishes), $sampled(instr_finishes_o));
  branch_a : assert property (@(posedge clk_i) armed |-> branch_taken_o == exp_branch)
    else flag_mismatch("branch_taken_o", $sampled(exp_branch), $sampled(branch_taken_o));
  jump_a : assert property (@(posedge clk_i) armed |-> is_jump_o == exp_jump)
    else flag_mismatch("is_jump_o", $sampled(exp_jump), $sampled(is_jump_o));
  branch_target_a : assert property (@(posedge clk_i)
    armed && instr_i[6:0] == params_pkg::OP_BRANCH |-> pc_branch_offset_o == exp_target)
    else flag_mismatch("pc_branch_offset_o", $sampled(exp_target),
                       $sampled(pc_branch_offset_o));
  jump_target_a : assert property (@(posedge clk_i)
    armed && instr_i[6:0] == params_pkg::OP_JAL |-> jump_address_o == exp_target)
    else flag_mismatch("jump_address_o", $sampled(exp_target), $sampled(jump_address_o));

  // Registered side runs one cycle behind.
  mem_valid_a : assert property (@(posedge clk_i) armed |-> mem_valid_o == held_valid)
    else flag_mismatch("mem_valid_o", $sampled(held_valid), $sampled(mem_valid_o));
  mem_load_a : assert property (@(posedge clk_i) armed |-> mem_is_load_o == held_load)
    else flag_mismatch("mem_is_load_o", $sampled(held_load), $sampled(mem_is_load_o));
  mem_store_a : assert property (@(posedge clk_i) armed |-> mem_is_store_o == held_store)
    else flag_mismatch("mem_is_store_o", $sampled(held_store), $sampled(mem_is_store_o));
  mem_wr_en_a : assert property (@(posedge clk_i) armed |-> mem_reg_wr_en_o == held_load)
    else flag_mismatch("mem_reg_wr_en_o", $sampled(held_load), $sampled(mem_reg_wr_en_o));
  mem_size_a : assert property (@(posedge clk_i) armed && (held_load || held_store) |->
    mem_access_size_o == held_access)
    else flag_mismatch("mem_access_size_o", $sampled(held_access),
                       $sampled(mem_access_size_o));
  mem_addr_a : assert property (@(posedge clk_i) armed && (held_load || held_store) |->
    mem_alu_result_o == held_result)
    else flag_mismatch("mem_alu_result_o", $sampled(held_result), $sampled(mem_alu_result_o));
  mem_rs2_a : assert property (@(posedge clk_i) armed && (held_load || held_store) |->
    mem_rs2_data_o == held_rs2)
    else flag_mismatch("mem_rs2_data_o", $sampled(held_rs2), $sampled(mem_rs2_data_o));
  reset_clears_a : assert property (@(posedge clk_i) rst_i |=>
    !(mem_valid_o || mem_is_load_o || mem_is_store_o || mem_reg_wr_en_o)
    && mem_alu_result_o == '0 && mem_rs2_data_o == '0)
    else begin
      $display("reset before %0t did not clear the EX/MEM register", $time);
      error_count++;
    end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  function automatic logic [31:0] rand_word();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    // Fold the high bits down since the low LCG bits repeat quickly.
    return lcg_state ^ (lcg_state >> 16);
  endfunction

  // SLTU is not in the ALU set.
  function automatic logic [2:0] pick_alu_f3(input logic [31:0] r);
    return (r[31:29] == 3'b011) ? 3'b101 : r[31:29];
  endfunction

  task automatic drive_slot(input logic v, input logic [31:0] ins, input logic [31:0] pc,
                            input logic [31:0] a, input logic [31:0] b);
    @(posedge clk_i);
    valid_i  <= v;
    instr_i  <= ins;
    pc_i     <= pc;
    data_a_i <= a;
    data_b_i <= b;
  endtask

  task automatic end_test(input string name);
    int errs;
    drive_slot(1'b0, '0, '0, '0, '0);
    repeat (DRAIN_CYCLES - 1) @(posedge clk_i);
    #1;
    errs = error_count - test_start_errors;
    tests_run++;
    if (errs != 0) begin
      tests_failed++;
    end
    $display("test %-12s %0d errors", name, errs);
    test_start_errors = error_count;
  endtask

  task automatic issue_r_type();
    logic [31:0] r;
    logic [31:0] ins;
    logic [31:0] pc;
    logic [31:0] a;
    for (int i = 0; i < R_SLOTS; i++) begin
      r   = rand_word();
      ins = {1'b0, r[28], 5'b0, r[24:15], pick_alu_f3(rand_word()), r[11:7], params_pkg::OP_R};
      pc  = rand_word();
      a   = rand_word();
      drive_slot(r[27:26] != 2'b00, ins, pc, a, rand_word());
    end
  endtask

  task automatic sweep_immediates();
    logic [31:0] r;
    logic [31:0] ins;
    logic [31:0] pc;
    logic [31:0] a;
    for (int i = 0; i < IMM_SLOTS; i++) begin
      r = rand_word();
      case (i % 4)
        0, 1: ins = {r[31:15], pick_alu_f3(rand_word()), r[11:7], params_pkg::OP_IMM};
        2: ins = {r[31:7], params_pkg::OP_LUI};
        default: ins = {r[31:7], params_pkg::OP_AUIPC};
      endcase
      pc = rand_word();
      a  = rand_word();
      drive_slot(1'b1, ins, pc, a, r);
    end
  endtask

  task automatic exercise_branches();
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    for (int i = 0; i < BR_SLOTS; i++) begin
      r = rand_word();
      a = rand_word();
      b = rand_word();
      if (r[3:2] == 2'b00) begin
        b = a;
      end
      // Funct3 lands on BEQ, BNE, BLT or BGE.
      drive_slot(r[5:4] != 2'b00, {r[31:15], r[1], 1'b0, r[0], r[11:7], params_pkg::OP_BRANCH},
                 rand_word(), a, b);
    end
  endtask

  task automatic send_jal();
    logic [31:0] r;
    logic [31:0] s;
    for (int i = 0; i < JAL_SLOTS; i++) begin
      r = rand_word();
      s = rand_word();
      drive_slot(s[1:0] != 2'b00, {r[31:7], params_pkg::OP_JAL}, {s[31:2], 2'b00}, r, s);
    end
  endtask

  task automatic mix_loads_stores();
    logic [31:0] r;
    logic [31:0] s;
    logic [31:0] a;
    for (int i = 0; i < MEM_SLOTS; i++) begin
      r = rand_word();
      s = rand_word();
      a = rand_word();
      drive_slot(s[2:1] != 2'b00,
                 {r[31:7], s[0] ? params_pkg::OP_LOAD : params_pkg::OP_STORE}, '0, a, s);
    end
  endtask

  task automatic stall_then_reset();
    logic [31:0] r;
    r = rand_word();
    drive_slot(1'b1, {r[31:15], 3'b010, r[11:7], params_pkg::OP_LOAD}, '0, r, ~r);
    // A store arrives as the memory stage stalls, and waits.
    r = rand_word();
    drive_slot(1'b1, {r[31:15], 3'b000, r[11:7], params_pkg::OP_STORE}, '0, ~r, r);
    mem_stall_i <= 1'b1;
    repeat (STALL_HOLD) @(posedge clk_i);
    mem_stall_i <= 1'b0;
    r = rand_word();
    drive_slot(1'b1, {r[31:15], 3'b001, r[11:7], params_pkg::OP_LOAD}, '0, r, r);
    @(posedge clk_i);
    rst_i <= 1'b1;
    @(posedge clk_i);
    rst_i <= 1'b0;
  endtask

  // ----------------------------------------
  // Main sequence and timeout
  // ----------------------------------------
  initial begin
    lcg_state    = 32'he3fa;
    armed        = 1'b0;
    rst_i        = 1'b1;
    valid_i      = 1'b0;
    mem_stall_i  = 1'b0;
    instr_i      = '0;
    pc_i         = '0;
    data_a_i     = '0;
    data_b_i     = '0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_i <= 1'b0;
    armed <= 1'b1;
    test_start_errors = error_count;
    issue_r_type();
    end_test("r_type");
    sweep_immediates();
    end_test("immediate");
    exercise_branches();
    end_test("branch");
    send_jal();
    end_test("jal");
    mix_loads_stores();
    end_test("load_store");
    stall_then_reset();
    end_test("stall_reset");
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("timeout after %0d cycles, the tests did not finish", cycle_count);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule : exec_unit_tb

`default_nettype wire

//--- all.f
+incdir+bench
src/params_pkg.sv
src/imm_decode.sv
src/alu.sv
src/alu_stage.sv
src/ex_mem_reg.sv
src/exec_unit.sv
bench/exec_unit_tb.sv

//--- Bender.yml
package:
  name: exec_unit

sources:
  - src/params_pkg.sv
  - src/imm_decode.sv
  - src/alu.sv
  - src/alu_stage.sv
  - src/ex_mem_reg.sv
  - src/exec_unit.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/exec_unit_tb.sv
